/* rtl/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

  // ========================================
  // widths

  localparam int lanes              = 4;  // instructions per fetch group
  localparam int rob_depth_log2_max = 6;  // widest ROB slot number an entry can hold

  typedef logic [rob_depth_log2_max-1:0] rob_slot_t;

  // ========================================
  // decoded instruction

  typedef enum logic [2:0] {
    alu_reg,
    alu_imm,
    load,
    store,
    branch,
    jump,     // jal and jalr
    upper,    // lui and auipc
    illegal
  } op_class_t;

  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op_class;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        rs1_valid;
    logic        rs2_valid;
    logic        dest_reg_valid;
    logic [31:0] imm;            // sign extended, already shifted for b/j/u
    logic [2:0]  funct3;
    logic        funct7_bit;     // inst[30], sub/sra select
    logic [20:0] pad;            // keeps the struct at 110 bits
  } dec_inst_t;

  typedef struct packed {
    dec_inst_t dec_inst;
    rob_slot_t rob_slot;
    logic      stream;
  } iq_entry_t;

endpackage

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
  input  wire [31:0]              pc,
  input  wire [31:0]              inst_word,
  output dispatch_pkg::dec_inst_t di
);
  import dispatch_pkg::*;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;

  logic [6:0]  opcode;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic        has_dest;

  assign opcode = inst_word[6:0];

  assign imm_i = {{20{inst_word[31]}}, inst_word[31:20]};
  assign imm_s = {{20{inst_word[31]}}, inst_word[31:25], inst_word[11:7]};
  assign imm_b = {{19{inst_word[31]}}, inst_word[31], inst_word[7],
                  inst_word[30:25], inst_word[11:8], 1'b0};
  assign imm_u = {inst_word[31:12], 12'b0};
  assign imm_j = {{11{inst_word[31]}}, inst_word[31], inst_word[19:12],
                  inst_word[20], inst_word[30:21], 1'b0};

  always_comb begin
    di            = '0;
    has_dest      = 1'b0;
    di.pc         = pc;
    di.rs1        = inst_word[19:15];
    di.rs2        = inst_word[24:20];
    di.rd         = inst_word[11:7];
    di.funct3     = inst_word[14:12];
    di.funct7_bit = inst_word[30];
    di.op_class   = illegal;

    case (opcode)
      opc_op: begin
        di.op_class  = alu_reg;
        di.rs1_valid = 1'b1;
        di.rs2_valid = 1'b1;
        has_dest     = 1'b1;
      end
      opc_op_imm, opc_load: begin
        di.op_class  = (opcode == opc_load) ? load : alu_imm;
        di.rs1_valid = 1'b1;
        di.imm       = imm_i;
        has_dest     = 1'b1;
      end
      opc_store: begin
        di.op_class  = store;
        di.rs1_valid = 1'b1;
        di.rs2_valid = 1'b1;
        di.imm       = imm_s;
      end
      opc_branch: begin
        di.op_class  = branch;
        di.rs1_valid = 1'b1;
        di.rs2_valid = 1'b1;
        di.imm       = imm_b;
      end
      opc_jal: begin
        di.op_class = jump;
        di.imm      = imm_j;
        has_dest    = 1'b1;
      end
      opc_jalr: begin
        di.op_class  = jump;
        di.rs1_valid = 1'b1;
        di.imm       = imm_i;
        has_dest     = 1'b1;
      end
      opc_lui, opc_auipc: begin
        di.op_class = upper;
        di.imm      = imm_u;
        has_dest    = 1'b1;
      end
      default: di.op_class = illegal;  // no sources, no destination
    endcase

    di.dest_reg_valid = has_dest && (di.rd != 5'd0);  // x0 writes are dropped
  end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage #(
  parameter int rob_depth_log2 = 4
) (
  input  wire                      clock,
  input  wire                      reset_n,
  input  wire [31:0]               inst_word[dispatch_pkg::lanes],
  input  wire [31:0]               inst_pc[dispatch_pkg::lanes],
  input  wire                      inst_word_valid[dispatch_pkg::lanes],
  input  wire                      inst_stream,
  input  wire                      flush,
  input  wire                      flush_stream,
  input  wire [rob_depth_log2-1:0] reserved_slots[dispatch_pkg::lanes],
  input  wire                      rob_full,
  input  wire                      iq_full,
  output logic                     stall,
  output logic                     reserve,
  output logic [1:0]               reserve_count,
  output logic                     ins_enable,
  output logic [1:0]               new_count,
  output dispatch_pkg::iq_entry_t  new_elements[dispatch_pkg::lanes],
  output logic [4:0]               dest_reg[dispatch_pkg::lanes],
  output logic                     dest_reg_valid[dispatch_pkg::lanes]
);
  import dispatch_pkg::*;

  dec_inst_t  dec_inst[lanes];
  logic [1:0] lane_sel[lanes];  // source lane for each compacted slot
  logic [2:0] valid_count;
  logic       any_valid;
  logic       flush_pending;
  logic       flush_stream_r;
  logic       discard;
  logic       accept;

  for (genvar g = 0; g < lanes; g++) begin : g_dec
    inst_decoder dec_i (
      .pc        (inst_pc[g]),
      .inst_word (inst_word[g]),
      .di        (dec_inst[g])
    );
  end

  // ========================================
  // flush tracking

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      flush_pending  <= 1'b0;
      flush_stream_r <= 1'b0;
    end else if (flush && (inst_stream == flush_stream)) begin
      flush_pending  <= 1'b1;
      flush_stream_r <= flush_stream;
    end else if (flush_pending && (inst_stream != flush_stream_r)) begin
      flush_pending  <= 1'b0;  // fetch has moved to the other stream
    end
  end

  assign discard = (flush && (inst_stream == flush_stream))
                 || (flush_pending && (inst_stream == flush_stream_r));

  // ========================================
  // lane count and compaction

  always_comb begin
    valid_count = 3'd0;
    for (int k = 0; k < lanes; k++) begin
      lane_sel[k] = 2'd3;
    end
    for (int i = 0; i < lanes; i++) begin
      if (inst_word_valid[i]) begin
        lane_sel[valid_count[1:0]] = 2'(i);  // k-th valid lane lands in slot k
        valid_count                = valid_count + 3'd1;
      end
    end
  end

  assign any_valid     = (valid_count != 3'd0);
  assign stall         = rob_full | iq_full;
  assign accept        = any_valid && !stall && !discard;
  assign reserve       = accept;
  assign ins_enable    = accept;
  assign reserve_count = 2'(valid_count - 3'd1);  // minus-one encoding
  assign new_count     = reserve_count;

  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      new_elements[k].dec_inst = dec_inst[lane_sel[k]];
      new_elements[k].rob_slot = rob_slot_t'(reserved_slots[k]);
      new_elements[k].stream   = inst_stream;
      dest_reg[k]              = dec_inst[lane_sel[k]].rd;
      dest_reg_valid[k]        = (k < valid_count) && dec_inst[lane_sel[k]].dest_reg_valid;
    end
  end

  // ========================================
  // checks

  // a stream flushed last cycle stays dropped while fetch still shows it
  a_flushed_stream_dropped : assert property (
    @(posedge clock) disable iff (!reset_n)
    ($past(flush && (inst_stream == flush_stream)) && (inst_stream == $past(flush_stream)))
      |-> !(reserve || ins_enable)
  );

endmodule

`default_nettype wire

/* rtl/rob_slot_allocator.sv */
`timescale 1ns/100ps
`default_nettype none

module rob_slot_allocator #(
  parameter int rob_depth_log2 = 4
) (
  input  wire                       clock,
  input  wire                       reset_n,
  input  wire                       reserve,
  input  wire [1:0]                 reserve_count,
  input  wire                       retire_valid,
  input  wire [1:0]                 retire_count,
  output logic [rob_depth_log2-1:0] reserved_slots[dispatch_pkg::lanes],
  output logic                      rob_full
);
  import dispatch_pkg::*;

  localparam int depth   = 1 << rob_depth_log2;
  localparam int count_w = rob_depth_log2 + 1;

  localparam logic [count_w-1:0] full_level = count_w'(depth - lanes);

  logic [rob_depth_log2-1:0] tail;   // next slot to hand out
  logic [count_w-1:0]        count;  // slots reserved and not yet retired
  logic [2:0]                reserve_num;
  logic [2:0]                retire_num;

  assign reserve_num = reserve ? ({1'b0, reserve_count} + 3'd1) : 3'd0;
  assign retire_num  = retire_valid ? ({1'b0, retire_count} + 3'd1) : 3'd0;

  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      reserved_slots[k] = tail + rob_depth_log2'(k);  // wraps at depth
    end
  end

  assign rob_full = (count > full_level);  // fewer than four free

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      tail  <= '0;
      count <= '0;
    end else begin
      tail  <= tail + rob_depth_log2'(reserve_num);
      count <= count + count_w'(reserve_num) - count_w'(retire_num);
    end
  end

  // ========================================
  // checks

  a_no_reserve_when_full : assert property (
    @(posedge clock) disable iff (!reset_n)
    reserve |-> !rob_full
  );

  a_retire_within_occupancy : assert property (
    @(posedge clock) disable iff (!reset_n)
    retire_valid |-> (count_w'(retire_num) <= count)
  );

endmodule

`default_nettype wire

/* rtl/issue_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_queue #(
  parameter int iq_depth_log2 = 3
) (
  input  wire                           clock,
  input  wire                           reset_n,
  input  wire                           ins_enable,
  input  wire [1:0]                     new_count,
  input  wire dispatch_pkg::iq_entry_t  new_elements[dispatch_pkg::lanes],
  input  wire                           issue_ready,
  output logic                          iq_full,
  output logic                          issue_valid,
  output dispatch_pkg::iq_entry_t       issue_entry
);
  import dispatch_pkg::*;

  localparam int depth   = 1 << iq_depth_log2;
  localparam int count_w = iq_depth_log2 + 1;

  localparam logic [count_w-1:0] full_level = count_w'(depth - lanes);

  iq_entry_t                mem[depth];
  logic [iq_depth_log2-1:0] head;        // oldest entry
  logic [iq_depth_log2-1:0] tail;        // first free entry
  logic [count_w-1:0]       count;
  logic [iq_depth_log2-1:0] wr_ptr[lanes];
  logic [2:0]               wr_num;
  logic                     do_issue;

  assign wr_num   = ins_enable ? ({1'b0, new_count} + 3'd1) : 3'd0;
  assign do_issue = issue_valid && issue_ready;

  always_comb begin
    for (int k = 0; k < lanes; k++) begin
      wr_ptr[k] = tail + iq_depth_log2'(k);
    end
  end

  // ========================================
  // storage

  always_ff @(posedge clock) begin
    for (int k = 0; k < lanes; k++) begin
      if (ins_enable && (k <= new_count)) begin
        mem[wr_ptr[k]] <= new_elements[k];  // slot k is the k-th oldest of the group
      end
    end
  end

  assign issue_entry = mem[head];
  assign issue_valid = (count != '0);
  assign iq_full     = (count > full_level);

  // ========================================
  // pointers

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      tail  <= tail + iq_depth_log2'(wr_num);
      count <= count + count_w'(wr_num) - count_w'(do_issue);
      if (do_issue) begin
        head <= head + 1'b1;
      end
    end
  end

  a_no_write_when_full : assert property (
    @(posedge clock) disable iff (!reset_n)
    ins_enable |-> !iq_full
  );

endmodule

`default_nettype wire

/* rtl/dispatch_front.sv */
`timescale 1ns/100ps
`default_nettype none

module dispatch_front #(
  parameter int rob_depth_log2 = 4,
  parameter int iq_depth_log2  = 3
) (
  input  wire                     clock,
  input  wire                     reset_n,
  input  wire [31:0]              inst_word[dispatch_pkg::lanes],
  input  wire [31:0]              inst_pc[dispatch_pkg::lanes],
  input  wire                     inst_word_valid[dispatch_pkg::lanes],
  input  wire                     inst_stream,
  output logic                    stall,
  input  wire                     flush,
  input  wire                     flush_stream,
  input  wire                     retire_valid,
  input  wire [1:0]               retire_count,
  output logic                    issue_valid,
  output dispatch_pkg::iq_entry_t issue_entry,
  input  wire                     issue_ready,
  output logic [4:0]              dest_reg[dispatch_pkg::lanes],
  output logic                    dest_reg_valid[dispatch_pkg::lanes]
);
  import dispatch_pkg::*;

  logic                      reserve;
  logic [1:0]                reserve_count;
  logic [rob_depth_log2-1:0] reserved_slots[lanes];
  logic                      rob_full;
  logic                      ins_enable;
  logic [1:0]                new_count;
  iq_entry_t                 new_elements[lanes];
  logic                      iq_full;

  decode_stage #(
    .rob_depth_log2 (rob_depth_log2)
  ) decode_stage_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .inst_word       (inst_word),
    .inst_pc         (inst_pc),
    .inst_word_valid (inst_word_valid),
    .inst_stream     (inst_stream),
    .flush           (flush),
    .flush_stream    (flush_stream),
    .reserved_slots  (reserved_slots),
    .rob_full        (rob_full),
    .iq_full         (iq_full),
    .stall           (stall),
    .reserve         (reserve),
    .reserve_count   (reserve_count),
    .ins_enable      (ins_enable),
    .new_count       (new_count),
    .new_elements    (new_elements),
    .dest_reg        (dest_reg),
    .dest_reg_valid  (dest_reg_valid)
  );

  rob_slot_allocator #(
    .rob_depth_log2 (rob_depth_log2)
  ) rob_slot_allocator_i (
    .clock          (clock),
    .reset_n        (reset_n),
    .reserve        (reserve),
    .reserve_count  (reserve_count),
    .retire_valid   (retire_valid),
    .retire_count   (retire_count),
    .reserved_slots (reserved_slots),
    .rob_full       (rob_full)
  );

  issue_queue #(
    .iq_depth_log2 (iq_depth_log2)
  ) issue_queue_i (
    .clock        (clock),
    .reset_n      (reset_n),
    .ins_enable   (ins_enable),
    .new_count    (new_count),
    .new_elements (new_elements),
    .issue_ready  (issue_ready),
    .iq_full      (iq_full),
    .issue_valid  (issue_valid),
    .issue_entry  (issue_entry)
  );

endmodule

`default_nettype wire

/* test/tb_dispatch_front.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dispatch_front;
  import dispatch_pkg::*;

  localparam int rob_depth_log2 = 4;
  localparam int iq_depth_log2  = 3;
  localparam int rob_depth      = 1 << rob_depth_log2;
  localparam int iq_depth       = 1 << iq_depth_log2;
  localparam int num_groups     = 160;
  localparam int wait_limit     = 80;   // cycles allowed for one wait
  localparam int retire_off_lo  = 120;  // retire held off in this cycle window
  localparam int retire_off_hi  = 170;
  localparam int issue_off_lo   = 260;  // issue_ready held low in this window
  localparam int issue_off_hi   = 300;

  logic        clock;
  logic        reset_n;
  logic [31:0] inst_word[lanes];
  logic [31:0] inst_pc[lanes];
  logic        inst_word_valid[lanes];
  logic        inst_stream;
  logic        stall;
  logic        flush;
  logic        flush_stream;
  logic        retire_valid;
  logic [1:0]  retire_count;
  logic        issue_valid;
  iq_entry_t   issue_entry;
  logic        issue_ready;
  logic [4:0]  dest_reg[lanes];
  logic        dest_reg_valid[lanes];

  logic [31:0] lfsr_state;
  iq_entry_t   expected_q[$];  // accepted and not yet issued
  int          outstanding;    // ROB slots reserved and not retired
  int          rob_next;
  int          cycle_n;
  int          errors;
  int          timeouts;
  int          drop_left;      // groups still to come from a flushed stream
  logic        cur_stream;
  logic        pend;
  logic        pend_stream;
  logic [31:0] group_pc;

  dispatch_front #(
    .rob_depth_log2 (rob_depth_log2),
    .iq_depth_log2  (iq_depth_log2)
  ) dispatch_front_i (
    .clock           (clock),
    .reset_n         (reset_n),
    .inst_word       (inst_word),
    .inst_pc         (inst_pc),
    .inst_word_valid (inst_word_valid),
    .inst_stream     (inst_stream),
    .stall           (stall),
    .flush           (flush),
    .flush_stream    (flush_stream),
    .retire_valid    (retire_valid),
    .retire_count    (retire_count),
    .issue_valid     (issue_valid),
    .issue_entry     (issue_entry),
    .issue_ready     (issue_ready),
    .dest_reg        (dest_reg),
    .dest_reg_valid  (dest_reg_valid)
  );

  always #2 clock = ~clock;

  // ========================================
  // random numbers and reference decode

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r          = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
    case (sel)
      4'd0, 4'd1, 4'd12: return 7'h33;  // op
      4'd2, 4'd3:        return 7'h13;  // op-imm
      4'd4, 4'd13:       return 7'h03;
      4'd5, 4'd14:       return 7'h23;
      4'd6, 4'd7:        return 7'h63;
      4'd8:              return 7'h6f;
      4'd9:              return 7'h67;
      4'd10:             return 7'h37;
      4'd11:             return 7'h17;
      default:           return 7'h7f;  // not an RV32I opcode
    endcase
  endfunction

  function automatic dec_inst_t expect_decode(input logic [31:0] pc, input logic [31:0] w);
    dec_inst_t d;
    logic      i_type;
    d            = '0;
    d.pc         = pc;
    d.rs1        = w[19:15];
    d.rs2        = w[24:20];
    d.rd         = w[11:7];
    d.funct3     = w[14:12];
    d.funct7_bit = w[30];
    case (w[6:0])
      7'h33:        d.op_class = alu_reg;
      7'h13:        d.op_class = alu_imm;
      7'h03:        d.op_class = load;
      7'h23:        d.op_class = store;
      7'h63:        d.op_class = branch;
      7'h6f, 7'h67: d.op_class = jump;
      7'h37, 7'h17: d.op_class = upper;
      default:      d.op_class = illegal;
    endcase
    i_type           = (d.op_class inside {alu_imm, load}) || (w[6:0] == 7'h67);  // jalr
    d.rs1_valid      = i_type || (d.op_class inside {alu_reg, store, branch});
    d.rs2_valid      = d.op_class inside {alu_reg, store, branch};
    d.dest_reg_valid = (d.op_class inside {alu_reg, alu_imm, load, jump, upper})
                       && (d.rd != 5'd0);
    if (i_type) begin
      d.imm = 32'($signed(w[31:20]));
    end else if (d.op_class == store) begin
      d.imm = 32'($signed({w[31:25], w[11:7]}));
    end else if (d.op_class == branch) begin
      d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    end else if (d.op_class == jump) begin
      d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    end else if (d.op_class == upper) begin
      d.imm = {w[31:12], 12'h000};
    end
    return d;
  endfunction

  // ========================================
  // checks

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, want);
    end
  endtask

  task automatic compare_entry(input iq_entry_t e);
    check_value("issue_entry.pc", issue_entry.dec_inst.pc, e.dec_inst.pc);
    check_value("issue_entry.op_class", 32'(issue_entry.dec_inst.op_class),
                32'(e.dec_inst.op_class));
    check_value("issue_entry.rd", 32'(issue_entry.dec_inst.rd), 32'(e.dec_inst.rd));
    check_value("issue_entry.dest_reg_valid", 32'(issue_entry.dec_inst.dest_reg_valid),
                32'(e.dec_inst.dest_reg_valid));
    check_value("issue_entry.rs1", 32'(issue_entry.dec_inst.rs1), 32'(e.dec_inst.rs1));
    check_value("issue_entry.rs2", 32'(issue_entry.dec_inst.rs2), 32'(e.dec_inst.rs2));
    check_value("issue_entry.rs1_valid", 32'(issue_entry.dec_inst.rs1_valid),
                32'(e.dec_inst.rs1_valid));
    check_value("issue_entry.rs2_valid", 32'(issue_entry.dec_inst.rs2_valid),
                32'(e.dec_inst.rs2_valid));
    check_value("issue_entry.imm", issue_entry.dec_inst.imm, e.dec_inst.imm);
    check_value("issue_entry.funct3", 32'(issue_entry.dec_inst.funct3),
                32'(e.dec_inst.funct3));
    check_value("issue_entry.funct7_bit", 32'(issue_entry.dec_inst.funct7_bit),
                32'(e.dec_inst.funct7_bit));
    check_value("issue_entry.rob_slot", 32'(issue_entry.rob_slot), 32'(e.rob_slot));
    check_value("issue_entry.stream", 32'(issue_entry.stream), 32'(e.stream));
  endtask

  // ========================================
  // stimulus

  task automatic drive_side();
    logic [31:0] r;
    int          n;
    r = rand_bits(2);
    issue_ready <= !(cycle_n >= issue_off_lo && cycle_n < issue_off_hi) && (r[1:0] != 2'd0);
    flush       <= 1'b0;
    r = rand_bits(1);
    if (!(cycle_n >= retire_off_lo && cycle_n < retire_off_hi) && outstanding > 0 && r[0]) begin
      n = int'(rand_bits(2));
      if (n > outstanding - 1) begin
        n = outstanding - 1;  // never more than is outstanding
      end
      retire_valid <= 1'b1;
      retire_count <= 2'(n);
    end else begin
      retire_valid <= 1'b0;
    end
  endtask

  task automatic present_group();
    logic [31:0] r;
    logic [3:0]  mask;
    logic        do_flush;
    do_flush = 1'b0;
    if (drop_left > 0) begin
      drop_left--;
      if (drop_left == 0) begin
        cur_stream = !cur_stream;  // fetch moves to the other stream
      end
    end else if (rand_bits(3) == 0) begin
      do_flush  = 1'b1;
      drop_left = 1 + int'(rand_bits(2));
    end
    r    = rand_bits(4);
    mask = (r[3:0] == 4'd0) ? 4'b1000 : r[3:0];
    for (int i = 0; i < lanes; i++) begin
      r = rand_bits(25);
      inst_word[i]       <= {r[24:0], pick_opcode(4'(rand_bits(4)))};
      inst_pc[i]         <= group_pc + 32'(4 * i);
      inst_word_valid[i] <= mask[i];
    end
    inst_stream  <= cur_stream;
    flush        <= do_flush;
    flush_stream <= cur_stream;
    group_pc = group_pc + 32'd16;
  endtask

  // sampled mid cycle, models what the next rising edge does
  task automatic observe_cycle(output logic done);
    logic      discard;
    logic      exp_stall;
    iq_entry_t e;
    int        slot;
    @(negedge clock);
    cycle_n++;
    exp_stall = (outstanding > rob_depth - lanes) || (expected_q.size() > iq_depth - lanes);
    check_value("stall", 32'(stall), 32'(exp_stall));
    check_value("issue_valid", 32'(issue_valid), 32'(expected_q.size() != 0));
    if (issue_valid && issue_ready) begin
      assert (expected_q.size() > 0) else begin
        errors++;
        $display("issue queue released an entry that was never accepted");
      end
      if (expected_q.size() > 0) begin
        e = expected_q.pop_front();
        compare_entry(e);
      end
    end
    if (retire_valid) begin
      outstanding = outstanding - (int'(retire_count) + 1);
    end
    discard = (flush && inst_stream == flush_stream) || (pend && inst_stream == pend_stream);
    done    = discard;
    if (!discard && !stall) begin
      slot = 0;
      for (int i = 0; i < lanes; i++) begin
        if (inst_word_valid[i]) begin
          e.dec_inst = expect_decode(inst_pc[i], inst_word[i]);
          e.rob_slot = rob_slot_t'(rob_next);
          e.stream   = inst_stream;
          check_value("dest_reg", 32'(dest_reg[slot]), 32'(e.dec_inst.rd));
          check_value("dest_reg_valid", 32'(dest_reg_valid[slot]),
                      32'(e.dec_inst.dest_reg_valid));
          expected_q.push_back(e);
          rob_next = (rob_next + 1) % rob_depth;
          slot++;
        end
      end
      for (int k = slot; k < lanes; k++) begin
        check_value("dest_reg_valid", 32'(dest_reg_valid[k]), 32'h0);  // unused slot
      end
      outstanding = outstanding + slot;
      done        = 1'b1;
    end
    if (flush && inst_stream == flush_stream) begin
      pend        = 1'b1;
      pend_stream = flush_stream;
    end else if (pend && inst_stream != pend_stream) begin
      pend = 1'b0;
    end
  endtask

  task automatic run_groups();
    logic done;
    int   waited;
    for (int g = 0; g < num_groups; g++) begin
      @(posedge clock);
      drive_side();
      present_group();
      observe_cycle(done);
      waited = 0;
      while (!done) begin
        if (waited == wait_limit) begin
          timeouts++;
          $display("timeout: group %0d was not accepted within %0d cycles", g, wait_limit);
          return;
        end
        @(posedge clock);
        drive_side();
        observe_cycle(done);
        waited++;
      end
    end
    @(posedge clock);
    drive_side();
    for (int i = 0; i < lanes; i++) begin
      inst_word_valid[i] <= 1'b0;
    end
    observe_cycle(done);
    waited = 0;
    while (expected_q.size() > 0) begin  // drain
      if (waited == wait_limit) begin
        timeouts++;
        $display("timeout: %0d accepted entries never issued", expected_q.size());
        return;
      end
      @(posedge clock);
      drive_side();
      observe_cycle(done);
      waited++;
    end
  endtask

  initial begin
    clock        = 1'b0;
    lfsr_state   = 32'h67a1;
    outstanding  = 0;
    rob_next     = 0;
    cycle_n      = 0;
    errors       = 0;
    timeouts     = 0;
    drop_left    = 0;
    cur_stream   = 1'b0;
    pend         = 1'b0;
    pend_stream  = 1'b0;
    group_pc     = 32'h0000_1000;
    reset_n      <= 1'b0;
    inst_stream  <= 1'b0;
    flush        <= 1'b0;
    flush_stream <= 1'b0;
    retire_valid <= 1'b0;
    retire_count <= 2'd0;
    issue_ready  <= 1'b0;
    for (int i = 0; i < lanes; i++) begin
      inst_word[i]       <= '0;
      inst_pc[i]         <= '0;
      inst_word_valid[i] <= 1'b0;
    end
    repeat (8) @(posedge clock);
    reset_n <= 1'b1;
    run_groups();
    $display("closing: %0d failed checks, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dispatch_front.f */
rtl/dispatch_pkg.sv
rtl/inst_decoder.sv
rtl/decode_stage.sv
rtl/rob_slot_allocator.sv
rtl/issue_queue.sv
rtl/dispatch_front.sv
test/tb_dispatch_front.sv

/* run.sh */
#!/bin/sh
# builds the dispatch front testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f dispatch_front.f \
  --top-module tb_dispatch_front -o sim_dispatch_front
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_dispatch_front)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1
